/* build.f */
common/platform_pkg.sv
platform/axil_platform_port.sv
platform/machine_timer.sv
platform/gpio_outputs.sv
hw/platform_top.sv
sim/platform_tb.sv

/* common/platform_pkg.sv */
`default_nettype none

package platform_pkg;

    // Bus geometry
    localparam int PLAT_ADDR_W = 32;
    localparam int PLAT_DATA_W = 64;
    localparam int PLAT_STRB_W = PLAT_DATA_W / 8;

    // GPIO bank
    localparam int PLAT_NUM_OUTPUTS = 12;

    // At least one full 8-lane window rounded up to whole bytes
    localparam int PLAT_GPIO_SIZE =
        ((((PLAT_NUM_OUTPUTS > 8) ? PLAT_NUM_OUTPUTS : 8) + 7) / 8) * 8;

    // Byte offset inside the GPIO region
    localparam int PLAT_GPIO_OFF_W = $clog2(PLAT_GPIO_SIZE);

    // Register map as byte offsets from the slave base
    localparam int PLAT_MTIME_ADDR = 0;
    localparam int PLAT_MTIMECMP_ADDR = 8;
    localparam int PLAT_GPIO_BASE = 16;

    // Highest address where a full GPIO window still fits
    localparam int PLAT_GPIO_LAST = PLAT_GPIO_BASE + PLAT_GPIO_SIZE - PLAT_STRB_W;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // Write address channel
    typedef struct packed {
        logic [PLAT_ADDR_W-1:0] addr;
    } axil_aw_t;

    // Read address channel
    typedef struct packed {
        logic [PLAT_ADDR_W-1:0] addr;
    } axil_ar_t;

    // Write data channel
    typedef struct packed {
        logic [PLAT_DATA_W-1:0] data;
        logic [PLAT_STRB_W-1:0] strb;
    } axil_w_t;

    // Read data channel
    typedef struct packed {
        logic [PLAT_DATA_W-1:0] data;
        axil_resp_e             resp;
    } axil_r_t;

    // Write response channel
    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    // Internal write command qualified by a separate one-cycle enable.
    // For GPIO targets data holds the packed lane bits in its low byte
    typedef struct packed {
        logic [PLAT_DATA_W-1:0] data;
        logic [PLAT_STRB_W-1:0] strb;
    } plat_wr_t;

endpackage

`default_nettype wire

/* hw/platform_top.sv */
`timescale 1ns/1ps
`default_nettype none

module platform_top
    import platform_pkg::*;
(
    input  wire                          bus,
    input  wire                          rst,

    input  axil_aw_t                     aw,
    input  wire                          aw_valid,
    output logic                         aw_ready,
    input  axil_w_t                      w,
    input  wire                          w_valid,
    output logic                         w_ready,
    output axil_b_t                      b,
    output logic                         b_valid,
    input  wire                          b_ready,
    input  axil_ar_t                     ar,
    input  wire                          ar_valid,
    output logic                         ar_ready,
    output axil_r_t                      r,
    output logic                         r_valid,
    input  wire                          r_ready,

    output logic                         mtime_int,
    output logic [PLAT_NUM_OUTPUTS-1:0]  outputs
);

    logic                       timer_wr_en;
    logic                       timer_wr_sel;
    plat_wr_t                   timer_wr;
    logic                       gpio_wr_en;
    logic [PLAT_GPIO_OFF_W-1:0] gpio_wr_off;
    plat_wr_t                   gpio_wr;
    logic [PLAT_DATA_W-1:0]     mtime;
    logic [PLAT_DATA_W-1:0]     mtimecmp;

    axil_platform_port port_i (
        .bus          (bus),
        .rst          (rst),
        .aw           (aw),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w            (w),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .b            (b),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .ar           (ar),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .r            (r),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .timer_wr_en  (timer_wr_en),
        .timer_wr_sel (timer_wr_sel),
        .timer_wr     (timer_wr),
        .gpio_wr_en   (gpio_wr_en),
        .gpio_wr_off  (gpio_wr_off),
        .gpio_wr      (gpio_wr),
        .mtime        (mtime),
        .mtimecmp     (mtimecmp),
        .gpio_state   (outputs)
    );

    machine_timer timer_i (
        .bus       (bus),
        .rst       (rst),
        .wr_en     (timer_wr_en),
        .wr_sel    (timer_wr_sel),
        .wr        (timer_wr),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .mtime_int (mtime_int)
    );

    // GPIO read-back goes straight from the output pins to the port
    gpio_outputs gpio_i (
        .bus     (bus),
        .rst     (rst),
        .wr_en   (gpio_wr_en),
        .wr_off  (gpio_wr_off),
        .wr      (gpio_wr),
        .outputs (outputs)
    );

endmodule

`default_nettype wire

/* platform/axil_platform_port.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_platform_port
    import platform_pkg::*;
(
    input  wire                        bus,
    input  wire                        rst,

    input  axil_aw_t                   aw,
    input  wire                        aw_valid,
    output logic                       aw_ready,
    input  axil_w_t                    w,
    input  wire                        w_valid,
    output logic                       w_ready,
    output axil_b_t                    b,
    output logic                       b_valid,
    input  wire                        b_ready,
    input  axil_ar_t                   ar,
    input  wire                        ar_valid,
    output logic                       ar_ready,
    output axil_r_t                    r,
    output logic                       r_valid,
    input  wire                        r_ready,

    output logic                       timer_wr_en,
    output logic                       timer_wr_sel,
    output plat_wr_t                   timer_wr,
    output logic                       gpio_wr_en,
    output logic [PLAT_GPIO_OFF_W-1:0] gpio_wr_off,
    output plat_wr_t                   gpio_wr,
    input  wire  [PLAT_DATA_W-1:0]     mtime,
    input  wire  [PLAT_DATA_W-1:0]     mtimecmp,
    input  wire  [PLAT_NUM_OUTPUTS-1:0] gpio_state
);

    typedef enum logic [1:0] {
        REGION_MTIME,
        REGION_MTIMECMP,
        REGION_GPIO,
        REGION_ERR
    } region_e;

    function automatic region_e decode_region(input logic [PLAT_ADDR_W-1:0] addr);
        if (addr == PLAT_ADDR_W'(PLAT_MTIME_ADDR)) begin
            return REGION_MTIME;
        end else if (addr == PLAT_ADDR_W'(PLAT_MTIMECMP_ADDR)) begin
            return REGION_MTIMECMP;
        end else if (addr >= PLAT_ADDR_W'(PLAT_GPIO_BASE) &&
                     addr <= PLAT_ADDR_W'(PLAT_GPIO_LAST)) begin
            return REGION_GPIO;
        end
        return REGION_ERR;
    endfunction

    region_e                    rd_region;
    logic [PLAT_GPIO_OFF_W-1:0] rd_gpio_off;
    logic [PLAT_GPIO_SIZE-1:0]  gpio_padded;
    logic [PLAT_DATA_W-1:0]     rd_gpio_word;

    region_e                    wr_region;
    logic [PLAT_GPIO_OFF_W-1:0] wr_gpio_off;
    logic [PLAT_DATA_W-1:0]     wr_data;
    logic [PLAT_STRB_W-1:0]     wr_strb;
    logic [PLAT_DATA_W-1:0]     wr_gpio_bits;
    logic                       wr_fire;

    // Read side decode
    assign rd_region   = decode_region(ar.addr);
    assign rd_gpio_off = PLAT_GPIO_OFF_W'(ar.addr - PLAT_ADDR_W'(PLAT_GPIO_BASE));
    assign gpio_padded = PLAT_GPIO_SIZE'(gpio_state);

    // Spread the window so each output lands in bit 0 of a byte lane
    always_comb begin
        rd_gpio_word = '0;
        for (int i = 0; i < PLAT_STRB_W; i++) begin
            if (int'(rd_gpio_off) + i < PLAT_GPIO_SIZE) begin
                rd_gpio_word[8*i] = gpio_padded[int'(rd_gpio_off) + i];
            end
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            // Hold off new reads while a response is stalled
            ar_ready <= ar_valid && !ar_ready && (!r_valid || r_ready);
            if (ar_valid && ar_ready) begin
                r_valid <= 1'b1;
            end else if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge bus) begin
        if (ar_valid && ar_ready) begin
            r.data <= '0;
            r.resp <= RESP_OKAY;
            case (rd_region)
                REGION_MTIME:    r.data <= mtime;
                REGION_MTIMECMP: r.data <= mtimecmp;
                REGION_GPIO:     r.data <= rd_gpio_word;
                default:         r.resp <= RESP_SLVERR;
            endcase
        end
    end

    // Write side takes aw and w together
    assign wr_fire = aw_valid && aw_ready && w_valid && w_ready;

    always_ff @(posedge bus) begin
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            aw_ready <= aw_valid && w_valid && !aw_ready && !b_valid;
            w_ready  <= aw_valid && w_valid && !w_ready && !b_valid;
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end else if (wr_fire) begin
                b_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge bus) begin
        if (aw_valid && !b_valid) begin
            wr_region   <= decode_region(aw.addr);
            wr_gpio_off <= PLAT_GPIO_OFF_W'(aw.addr - PLAT_ADDR_W'(PLAT_GPIO_BASE));
        end
        if (w_valid && !b_valid) begin
            wr_data <= w.data;
            wr_strb <= w.strb;
        end
        if (wr_fire) begin
            b.resp <= (wr_region == REGION_ERR) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // bit 0 of every lane, packed into one byte
    always_comb begin
        wr_gpio_bits = '0;
        for (int i = 0; i < PLAT_STRB_W; i++) begin
            wr_gpio_bits[i] = wr_data[8*i];
        end
    end

    assign timer_wr_en   = wr_fire &&
                           (wr_region == REGION_MTIME || wr_region == REGION_MTIMECMP);
    assign timer_wr_sel  = (wr_region == REGION_MTIMECMP);
    assign timer_wr.data = wr_data;
    assign timer_wr.strb = wr_strb;

    assign gpio_wr_en    = wr_fire && (wr_region == REGION_GPIO);
    assign gpio_wr_off   = wr_gpio_off;
    assign gpio_wr.data  = wr_gpio_bits;
    assign gpio_wr.strb  = wr_strb;

endmodule

`default_nettype wire

/* platform/gpio_outputs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_outputs
    import platform_pkg::*;
(
    input  wire                         bus,
    input  wire                         rst,
    input  wire                         wr_en,
    input  wire  [PLAT_GPIO_OFF_W-1:0]  wr_off,
    input  plat_wr_t                    wr,
    output logic [PLAT_NUM_OUTPUTS-1:0] outputs
);

    logic [PLAT_GPIO_SIZE-1:0] gpio_q;
    logic [PLAT_GPIO_SIZE-1:0] gpio_d;

    // Strobe bit i moves packed bit i to register bit wr_off+i
    always_comb begin
        gpio_d = gpio_q;
        if (wr_en) begin
            for (int i = 0; i < PLAT_STRB_W; i++) begin
                if (wr.strb[i] && (int'(wr_off) + i < PLAT_GPIO_SIZE)) begin
                    gpio_d[int'(wr_off) + i] = wr.data[i];
                end
            end
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            gpio_q <= '0;
        end else begin
            gpio_q <= gpio_d;
        end
    end

    // Bits above the output count are storage only
    assign outputs = gpio_q[PLAT_NUM_OUTPUTS-1:0];

endmodule

`default_nettype wire

/* platform/machine_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module machine_timer
    import platform_pkg::*;
(
    input  wire                    bus,
    input  wire                    rst,
    input  wire                    wr_en,
    input  wire                    wr_sel,
    input  plat_wr_t               wr,
    output logic [PLAT_DATA_W-1:0] mtime,
    output logic [PLAT_DATA_W-1:0] mtimecmp,
    output logic                   mtime_int
);

    logic [PLAT_DATA_W-1:0] mtime_next;
    logic [PLAT_DATA_W-1:0] mtimecmp_next;

    // Written bytes take priority over the increment
    always_comb begin
        mtime_next = mtime + 1'b1;
        if (wr_en && !wr_sel) begin
            for (int i = 0; i < PLAT_STRB_W; i++) begin
                if (wr.strb[i]) begin
                    mtime_next[8*i +: 8] = wr.data[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        mtimecmp_next = mtimecmp;
        if (wr_en && wr_sel) begin
            for (int i = 0; i < PLAT_STRB_W; i++) begin
                if (wr.strb[i]) begin
                    mtimecmp_next[8*i +: 8] = wr.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '0;
        end else begin
            mtime    <= mtime_next;
            mtimecmp <= mtimecmp_next;
        end
    end

    // Level interrupt from an unsigned compare
    assign mtime_int = (mtime >= mtimecmp);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the platform testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module platform_tb \
    -f build.f -o platform_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/platform_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* sim/platform_stim.txt */
// op_addr_data_strb_resp_expdata_mask_outputs_irq, all hex
// op 0 write, 1 read, 2 wait for irq level in data bit 0, f end; irq f skips that check
1_00000000_0000000000000000_00_0_0000000000000000_FFFFFFFFFFFFFFFF_000_1
// Reset state then mtimecmp with partial strobes
1_00000008_0000000000000000_00_0_0000000000000000_FFFFFFFFFFFFFFFF_000_1
0_00000008_8877665544332211_FF_0_0000000000000000_0000000000000000_000_0
0_00000008_AAAAAAAAAAAAAAAA_5A_0_0000000000000000_0000000000000000_000_0
1_00000008_0000000000000000_00_0_88AA66AAAA33AA11_FFFFFFFFFFFFFFFF_000_0
0_00000008_9900000000000000_80_0_0000000000000000_0000000000000000_000_0
1_00000008_0000000000000000_00_0_99AA66AAAA33AA11_FFFFFFFFFFFFFFFF_000_0
// mtime just below mtimecmp, interrupt must rise
0_00000000_99AA66AAAA33AA00_FF_0_0000000000000000_0000000000000000_000_0
2_00000000_0000000000000001_00_0_0000000000000000_0000000000000000_000_1
1_00000000_0000000000000000_00_0_99AA66AAAA33AA00_FFFFFFFFFFFFFFC0_000_1
0_00000008_0000000000001000_FF_0_0000000000000000_0000000000000000_000_1
1_00000008_0000000000000000_00_0_0000000000001000_FFFFFFFFFFFFFFFF_000_1
0_00000000_0000000000002000_FF_0_0000000000000000_0000000000000000_000_1
1_00000000_0000000000000000_00_0_0000000000002000_FFFFFFFFFFFFFFC0_000_1
// GPIO lane writes and read-back
0_00000010_FE01010001010001_FF_0_0000000000000000_0000000000000000_06D_1
0_00000014_0101010101000101_0B_0_0000000000000000_0000000000000000_0FD_1
0_00000018_0000000000010101_05_0_0000000000000000_0000000000000000_5FD_1
1_00000010_0000000000000000_00_0_0101010101010001_FFFFFFFFFFFFFFFF_5FD_1
1_00000014_0000000000000000_00_0_0001000101010101_FFFFFFFFFFFFFFFF_5FD_1
1_00000018_0000000000000000_00_0_0000000000010001_FFFFFFFFFFFFFFFF_5FD_1
// Unmapped addresses
0_00000000_0000000000004000_FF_0_0000000000000000_0000000000000000_5FD_1
0_00000004_FFFFFFFFFFFFFFFF_FF_2_0000000000000000_0000000000000000_5FD_1
0_0000001C_FFFFFFFFFFFFFFFF_FF_2_0000000000000000_0000000000000000_5FD_1
0_00000100_FFFFFFFFFFFFFFFF_FF_2_0000000000000000_0000000000000000_5FD_1
1_00000000_0000000000000000_00_0_0000000000004000_FFFFFFFFFFFFFFC0_5FD_1
1_00000004_0000000000000000_00_2_0000000000000000_0000000000000000_5FD_1
1_0000001C_0000000000000000_00_2_0000000000000000_0000000000000000_5FD_1
1_00000100_0000000000000000_00_2_0000000000000000_0000000000000000_5FD_1
1_00000008_0000000000000000_00_0_0000000000001000_FFFFFFFFFFFFFFFF_5FD_1
1_00000010_0000000000000000_00_0_0101010101010001_FFFFFFFFFFFFFFFF_5FD_1
F_00000000_0000000000000000_00_0_0000000000000000_0000000000000000_000_F

/* sim/platform_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module platform_tb
    import platform_pkg::*;
();

    localparam int STIM_DEPTH  = 64;
    localparam int HS_TIMEOUT  = 100;
    localparam int IRQ_TIMEOUT = 400;

    localparam logic [3:0] OP_WRITE = 4'h0;
    localparam logic [3:0] OP_READ  = 4'h1;
    localparam logic [3:0] OP_IRQ   = 4'h2;
    localparam logic [3:0] OP_END   = 4'hf;
    localparam logic [3:0] IRQ_SKIP = 4'hf;

    // One line of the stim file
    typedef struct packed {
        logic [3:0]                  op;
        logic [PLAT_ADDR_W-1:0]      addr;
        logic [PLAT_DATA_W-1:0]      data;
        logic [PLAT_STRB_W-1:0]      strb;
        logic [3:0]                  resp;
        logic [PLAT_DATA_W-1:0]      exp_data;
        logic [PLAT_DATA_W-1:0]      mask;
        logic [PLAT_NUM_OUTPUTS-1:0] outs;
        logic [3:0]                  irq;
    } stim_rec_t;

    logic                        bus;
    logic                        rst;
    axil_aw_t                    aw;
    logic                        aw_valid;
    logic                        aw_ready;
    axil_w_t                     w;
    logic                        w_valid;
    logic                        w_ready;
    axil_b_t                     b;
    logic                        b_valid;
    logic                        b_ready;
    axil_ar_t                    ar;
    logic                        ar_valid;
    logic                        ar_ready;
    axil_r_t                     r;
    logic                        r_valid;
    logic                        r_ready;
    logic                        mtime_int;
    logic [PLAT_NUM_OUTPUTS-1:0] outputs;

    logic [$bits(stim_rec_t)-1:0] stim_mem [STIM_DEPTH];

    // Expected timer state built from the writes issued so far
    logic [PLAT_DATA_W-1:0] cmp_model;
    logic [PLAT_DATA_W-1:0] mtime_base;
    bit                     mtime_base_ok;

    int resp_errors;
    int data_errors;
    int pin_errors;
    int timeout_errors;
    int stim_errors;

    platform_top dut_i (
        .bus       (bus),
        .rst       (rst),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .mtime_int (mtime_int),
        .outputs   (outputs)
    );

    initial begin
        bus = 1'b0;
        forever #2 bus = ~bus;
    end

    function automatic logic [PLAT_DATA_W-1:0] lane_mask(input logic [PLAT_STRB_W-1:0] strb);
        logic [PLAT_DATA_W-1:0] mask;
        for (int i = 0; i < PLAT_STRB_W; i++) begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        return mask;
    endfunction

    task automatic axil_write(
        input  logic [PLAT_ADDR_W-1:0] addr,
        input  logic [PLAT_DATA_W-1:0] data,
        input  logic [PLAT_STRB_W-1:0] strb,
        output logic [1:0]             resp,
        output bit                     ok
    );
        int cycles;
        ok       = 1'b0;
        resp     = 2'b00;
        aw.addr  <= addr;
        w.data   <= data;
        w.strb   <= strb;
        aw_valid <= 1'b1;
        w_valid  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge bus);
            cycles++;
        end while (!(aw_ready && w_ready) && cycles < HS_TIMEOUT);
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        if (!(aw_ready && w_ready)) begin
            $display("Write to address 0x%h was not accepted in time", addr);
            timeout_errors++;
            return;
        end
        b_ready <= 1'b1;
        cycles = 0;
        do begin
            @(posedge bus);
            cycles++;
        end while (!b_valid && cycles < HS_TIMEOUT);
        b_ready <= 1'b0;
        if (!b_valid) begin
            $display("No write response for address 0x%h", addr);
            timeout_errors++;
            return;
        end
        resp = b.resp;
        ok   = 1'b1;
    endtask

    task automatic axil_read(
        input  logic [PLAT_ADDR_W-1:0] addr,
        output logic [PLAT_DATA_W-1:0] data,
        output logic [1:0]             resp,
        output bit                     ok
    );
        int cycles;
        ok       = 1'b0;
        data     = '0;
        resp     = 2'b00;
        ar.addr  <= addr;
        ar_valid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge bus);
            cycles++;
        end while (!ar_ready && cycles < HS_TIMEOUT);
        ar_valid <= 1'b0;
        if (!ar_ready) begin
            $display("Read of address 0x%h was not accepted in time", addr);
            timeout_errors++;
            return;
        end
        r_ready <= 1'b1;
        cycles = 0;
        do begin
            @(posedge bus);
            cycles++;
        end while (!r_valid && cycles < HS_TIMEOUT);
        r_ready <= 1'b0;
        if (!r_valid) begin
            $display("No read data for address 0x%h", addr);
            timeout_errors++;
            return;
        end
        data = r.data;
        resp = r.resp;
        ok   = 1'b1;
    endtask

    task automatic check_read(
        input stim_rec_t              rec,
        input logic [PLAT_DATA_W-1:0] data,
        input logic [1:0]             resp
    );
        logic [PLAT_DATA_W-1:0] mask;
        mask = rec.mask;
        // The running count in the low bits of mtime is left to the range check
        if (rec.addr == PLAT_ADDR_W'(PLAT_MTIME_ADDR)) begin
            mask[5:0] = '0;
        end
        if (resp != rec.resp[1:0]) begin
            $display("Error r.resp: got 0x%h expected 0x%h at address 0x%h",
                     resp, rec.resp[1:0], rec.addr);
            resp_errors++;
        end
        if ((data & mask) != (rec.exp_data & mask)) begin
            $display("Error r.data: got 0x%h expected 0x%h mask 0x%h at address 0x%h",
                     data, rec.exp_data, mask, rec.addr);
            data_errors++;
        end
        if (rec.addr == PLAT_ADDR_W'(PLAT_MTIMECMP_ADDR) && data != cmp_model) begin
            $display("Error mtimecmp: got 0x%h expected 0x%h", data, cmp_model);
            data_errors++;
        end
        // mtime keeps counting, so only a short window after the last write is valid
        if (rec.addr == PLAT_ADDR_W'(PLAT_MTIME_ADDR) && mtime_base_ok &&
            (data < mtime_base || data >= mtime_base + 64)) begin
            $display("Error mtime: got 0x%h expected 0x%h to 0x%h",
                     data, mtime_base, mtime_base + 63);
            data_errors++;
        end
    endtask

    task automatic run_record(input stim_rec_t rec);
        logic [1:0]             resp;
        logic [PLAT_DATA_W-1:0] data;
        bit                     ok;
        int                     cycles;
        case (rec.op)
            OP_WRITE: begin
                axil_write(rec.addr, rec.data, rec.strb, resp, ok);
                if (ok && resp != rec.resp[1:0]) begin
                    $display("Error b.resp: got 0x%h expected 0x%h at address 0x%h",
                             resp, rec.resp[1:0], rec.addr);
                    resp_errors++;
                end
                if (rec.addr == PLAT_ADDR_W'(PLAT_MTIMECMP_ADDR)) begin
                    cmp_model = (cmp_model & ~lane_mask(rec.strb)) |
                                (rec.data & lane_mask(rec.strb));
                end
                if (rec.addr == PLAT_ADDR_W'(PLAT_MTIME_ADDR)) begin
                    mtime_base    = rec.data;
                    mtime_base_ok = (rec.strb == '1);
                end
            end
            OP_READ: begin
                axil_read(rec.addr, data, resp, ok);
                if (ok) begin
                    check_read(rec, data, resp);
                end
            end
            OP_IRQ: begin
                cycles = 0;
                do begin
                    @(negedge bus);
                    cycles++;
                end while (mtime_int !== rec.data[0] && cycles < IRQ_TIMEOUT);
                if (mtime_int !== rec.data[0]) begin
                    $display("mtime_int did not reach level %0d in time", rec.data[0]);
                    timeout_errors++;
                end
            end
            default: begin
                $display("Unknown operation 0x%h in the stim file", rec.op);
                stim_errors++;
            end
        endcase
        @(negedge bus);
        if (outputs !== rec.outs) begin
            $display("Error outputs: got 0x%h expected 0x%h", outputs, rec.outs);
            pin_errors++;
        end
        if (rec.irq != IRQ_SKIP && mtime_int !== rec.irq[0]) begin
            $display("Error mtime_int: got 0x%h expected 0x%h", mtime_int, rec.irq[0]);
            pin_errors++;
        end
    endtask

    initial begin
        stim_rec_t rec;
        bit        found_end;
        int        total;
        rst            = 1'b1;
        aw             = '0;
        aw_valid       = 1'b0;
        w              = '0;
        w_valid        = 1'b0;
        b_ready        = 1'b0;
        ar             = '0;
        ar_valid       = 1'b0;
        r_ready        = 1'b0;
        cmp_model      = '0;
        // mtime starts from zero when reset is released
        mtime_base     = '0;
        mtime_base_ok  = 1'b1;
        resp_errors    = 0;
        data_errors    = 0;
        pin_errors     = 0;
        timeout_errors = 0;
        stim_errors    = 0;
        found_end      = 1'b0;
        $readmemh("sim/platform_stim.txt", stim_mem);

        repeat (5) @(posedge bus);
        rst <= 1'b0;

        for (int i = 0; i < STIM_DEPTH && !found_end; i++) begin
            rec = stim_rec_t'(stim_mem[i]);
            if (rec.op == OP_END) begin
                found_end = 1'b1;
            end else begin
                @(posedge bus);
                run_record(rec);
            end
        end
        if (!found_end) begin
            $display("The stim file has no end marker");
            stim_errors++;
        end

        total = resp_errors + data_errors + pin_errors + timeout_errors + stim_errors;
        $display("Errors: response %0d, data %0d, pin %0d, timeout %0d, stim %0d",
                 resp_errors, data_errors, pin_errors, timeout_errors, stim_errors);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
